/* Bender.yml */
package:
  name: routerArb

sources:
  - files:
      - rtl/routerPkg.sv
      - rtl/portBundleIf.sv
      - rtl/portRegister.sv
      - rtl/grantTimer.sv
      - rtl/switchArbiter.sv
      - rtl/crossbarStage.sv
      - rtl/routerArbTop.sv
  - target: test
    files:
      - verif/routerArb_props.sv
      - verif/routerArbTb.sv

/* project.f */
rtl/routerPkg.sv
rtl/portBundleIf.sv
rtl/portRegister.sv
rtl/grantTimer.sv
rtl/switchArbiter.sv
rtl/crossbarStage.sv
rtl/routerArbTop.sv
verif/routerArb_props.sv
verif/routerArbTb.sv

/* rtl/crossbarStage.sv */
`timescale 1ns/1ps

module crossbarStage (
  input  logic               clk,
  input  logic               rst,
  portBundleIf.xbar          bundle,
  input  routerPkg::portSelT grant,
  output routerPkg::flitT    outFlit,
  output routerPkg::portSelT outPort,
  output logic               outValid
);

  routerPkg::flitT flitDly [routerPkg::NumPorts];
  routerPkg::flitT selFlit;

  // lines the flits up with the grant.
  always_ff @(posedge clk)
  begin
    for (int i = 0; i < routerPkg::NumPorts; i++)
    begin
      flitDly[i] <= bundle.flit[i];
    end
  end

  // and-or mux, idle gives zero.
  always_comb
  begin
    selFlit = '0;
    for (int i = 0; i < routerPkg::NumPorts; i++)
    begin
      if (grant[i+1])
      begin
        selFlit |= flitDly[i];
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outFlit <= '0;
      outPort <= '0;
      outValid <= 1'b0;
    end
    else
    begin
      outFlit <= selFlit;
      outPort <= grant;
      outValid <= (grant != routerPkg::ArbIdle);
    end
  end

endmodule

/* rtl/grantTimer.sv */
`timescale 1ns/1ps

module grantTimer (
  input  logic              clk,
  input  logic              rst,
  input  routerPkg::flitIdT flitId,
  input  routerPkg::pktLenT length,
  input  logic              runTimer,
  output logic              timesUp
);

  routerPkg::pktLenT limit;
  routerPkg::pktLenT count;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit <= '0;
      count <= '0;
    end
    else
    begin
      // length is only meaningful in a header.
      if (flitId == routerPkg::FlitIdHeader)
      begin
        limit <= length;
      end
      if (runTimer)
      begin
        count <= count + 12'd1;
      end
      else
      begin
        count <= '0;
      end
    end
  end

  assign timesUp = (count == limit);

endmodule

/* rtl/portBundleIf.sv */
`timescale 1ns/1ps

interface portBundleIf;

  // indexed local, north, east, west, south.
  routerPkg::flitT flit [routerPkg::NumPorts];
  logic [routerPkg::NumPorts-1:0] req;
  routerPkg::flitIdT flitId [routerPkg::NumPorts];
  routerPkg::pktLenT length [routerPkg::NumPorts];

  modport stage (
    output flit,
    output req,
    output flitId,
    output length
  );

  modport arb (
    input req,
    input flitId,
    input length
  );

  // crossbar only needs the payload.
  modport xbar (
    input flit
  );

endinterface

/* rtl/portRegister.sv */
`timescale 1ns/1ps

module portRegister (
  input  logic              clk,
  input  logic              rst,
  input  routerPkg::flitT   lFlit,
  input  routerPkg::flitT   nFlit,
  input  routerPkg::flitT   eFlit,
  input  routerPkg::flitT   wFlit,
  input  routerPkg::flitT   sFlit,
  input  logic              lReq,
  input  logic              nReq,
  input  logic              eReq,
  input  logic              wReq,
  input  logic              sReq,
  portBundleIf.stage        bundle
);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 0; i < routerPkg::NumPorts; i++)
      begin
        bundle.flit[i] <= '0;
      end
      bundle.req <= '0;
    end
    else
    begin
      bundle.flit[0] <= lFlit;
      bundle.flit[1] <= nFlit;
      bundle.flit[2] <= eFlit;
      bundle.flit[3] <= wFlit;
      bundle.flit[4] <= sFlit;
      bundle.req <= {sReq, wReq, eReq, nReq, lReq};
    end
  end

  // header fields for the timers.
  always_comb
  begin
    for (int i = 0; i < routerPkg::NumPorts; i++)
    begin
      bundle.flitId[i] =
        bundle.flit[i][routerPkg::FlitWidth-1 -: routerPkg::FlitIdWidth];
      bundle.length[i] = bundle.flit[i][routerPkg::PktLenWidth-1:0];
    end
  end

endmodule

/* rtl/routerArbTop.sv */
`timescale 1ns/1ps

module routerArbTop (
  input  logic               clk,
  input  logic               rst,
  input  routerPkg::flitT    lFlit,
  input  routerPkg::flitT    nFlit,
  input  routerPkg::flitT    eFlit,
  input  routerPkg::flitT    wFlit,
  input  routerPkg::flitT    sFlit,
  input  logic               lReq,
  input  logic               nReq,
  input  logic               eReq,
  input  logic               wReq,
  input  logic               sReq,
  output routerPkg::portSelT grant,
  output routerPkg::flitT    outFlit,
  output routerPkg::portSelT outPort,
  output logic               outValid
);

  portBundleIf bundle ();

  // stage 1.
  portRegister portReg (
    .clk    (clk),
    .rst    (rst),
    .lFlit  (lFlit),
    .nFlit  (nFlit),
    .eFlit  (eFlit),
    .wFlit  (wFlit),
    .sFlit  (sFlit),
    .lReq   (lReq),
    .nReq   (nReq),
    .eReq   (eReq),
    .wReq   (wReq),
    .sReq   (sReq),
    .bundle (bundle.stage)
  );

  // stage 2.
  switchArbiter arbiter (
    .clk    (clk),
    .rst    (rst),
    .bundle (bundle.arb),
    .grant  (grant)
  );

  // stage 3.
  crossbarStage xbar (
    .clk      (clk),
    .rst      (rst),
    .bundle   (bundle.xbar),
    .grant    (grant),
    .outFlit  (outFlit),
    .outPort  (outPort),
    .outValid (outValid)
  );

endmodule

/* rtl/routerPkg.sv */
package routerPkg;

  localparam int NumPorts = 5;
  localparam int FlitWidth = 16;
  localparam int FlitIdWidth = 3;
  localparam int PktLenWidth = 12;
  localparam int GrantWidth = NumPorts + 1;

  // flit id that marks the header of a packet.
  localparam logic [FlitIdWidth-1:0] FlitIdHeader = 3'b001;

  // id in the top bits, length in the low bits.
  typedef logic [FlitWidth-1:0] flitT;
  typedef logic [FlitIdWidth-1:0] flitIdT;

  // packet length in clock cycles.
  typedef logic [PktLenWidth-1:0] pktLenT;

  // one-hot grant, bit 0 is idle.
  typedef logic [GrantWidth-1:0] portSelT;

  typedef enum portSelT {
    ArbIdle  = 6'b000001,
    ArbLocal = 6'b000010,
    ArbNorth = 6'b000100,
    ArbEast  = 6'b001000,
    ArbWest  = 6'b010000,
    ArbSouth = 6'b100000
  } arbStateT;

endpackage

/* rtl/switchArbiter.sv */
`timescale 1ns/1ps

module switchArbiter (
  input  logic               clk,
  input  logic               rst,
  portBundleIf.arb           bundle,
  output routerPkg::portSelT grant
);

  routerPkg::arbStateT state;
  routerPkg::arbStateT nextState;
  logic [routerPkg::NumPorts-1:0] runTimer;
  logic [routerPkg::NumPorts-1:0] timesUp;
  logic [2:0] curIdx;
  logic [2:0] rotStart;
  logic granted;

  // first requester among span ports, from start on in rotation.
  function automatic routerPkg::arbStateT pickNext(
    input logic [routerPkg::NumPorts-1:0] reqs,
    input int start,
    input int span
  );
    routerPkg::arbStateT pick;
    int idx;
    pick = routerPkg::ArbIdle;
    for (int off = routerPkg::NumPorts - 1; off >= 0; off--)
    begin
      idx = (start + off) % routerPkg::NumPorts;
      if (off < span && reqs[idx])
      begin
        pick = routerPkg::arbStateT'(routerPkg::portSelT'(2) << idx);
      end
    end
    return pick;
  endfunction

  for (genvar p = 0; p < routerPkg::NumPorts; p++)
  begin : gTimer
    grantTimer timer (
      .clk      (clk),
      .rst      (rst),
      .flitId   (bundle.flitId[p]),
      .length   (bundle.length[p]),
      .runTimer (runTimer[p]),
      .timesUp  (timesUp[p])
    );
  end

  // index of the granted port.
  always_comb
  begin
    granted = 1'b1;
    curIdx = 3'd0;
    case (state)
      routerPkg::ArbLocal:
      begin
        curIdx = 3'd0;
      end
      routerPkg::ArbNorth:
      begin
        curIdx = 3'd1;
      end
      routerPkg::ArbEast:
      begin
        curIdx = 3'd2;
      end
      routerPkg::ArbWest:
      begin
        curIdx = 3'd3;
      end
      routerPkg::ArbSouth:
      begin
        curIdx = 3'd4;
      end
      default:
      begin
        granted = 1'b0;
      end
    endcase
  end

  assign rotStart = (curIdx == 3'(routerPkg::NumPorts - 1)) ? 3'd0 : curIdx + 3'd1;

  always_comb
  begin
    runTimer = '0;
    nextState = state;
    if (!granted)
    begin
      nextState = pickNext(bundle.req, 0, routerPkg::NumPorts);
    end
    else if (bundle.req[curIdx] && !timesUp[curIdx])
    begin
      runTimer[curIdx] = 1'b1;
      nextState = state;
    end
    else
    begin
      // the current port is skipped.
      nextState = pickNext(bundle.req, rotStart, routerPkg::NumPorts - 1);
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= routerPkg::ArbIdle;
    end
    else
    begin
      state <= nextState;
    end
  end

  assign grant = state;

endmodule

/* verif/routerArbTb.sv */
`timescale 1ns/1ps

module routerArbTb;

  bind routerArbTop routerArb_props props (
    .clk      (clk),
    .rst      (rst),
    .grant    (grant),
    .req      (bundle.req),
    .timesUp  (arbiter.timesUp),
    .outValid (outValid)
  );

  logic clk;
  logic rst;
  routerPkg::flitT inFlit [routerPkg::NumPorts];
  logic [routerPkg::NumPorts-1:0] inReq;
  routerPkg::portSelT grant;
  routerPkg::flitT outFlit;
  routerPkg::portSelT outPort;
  logic outValid;

  // model registers, one per pipeline register of the router.
  routerPkg::flitT mFlit [routerPkg::NumPorts];
  logic [routerPkg::NumPorts-1:0] mReq;
  routerPkg::pktLenT mLimit [routerPkg::NumPorts];
  routerPkg::pktLenT mCount [routerPkg::NumPorts];
  routerPkg::portSelT mState;
  routerPkg::flitT mDly [routerPkg::NumPorts];
  routerPkg::flitT mOutFlit;
  routerPkg::portSelT mOutPort;
  logic mOutValid;
  // flits sampled at the last three edges.
  routerPkg::flitT past0 [routerPkg::NumPorts];
  routerPkg::flitT past1 [routerPkg::NumPorts];
  routerPkg::flitT past2 [routerPkg::NumPorts];

  int seed;
  int errCount;
  int passCount;
  int failCount;
  int cycles;
  logic checking;
  // twice the summed test lengths: reset, single, rotation, drop, random.
  int cycleLimit = 2 * (8 + 30 + 50 + 40 + 420);

  routerArbTop dut (
    .clk      (clk),
    .rst      (rst),
    .lFlit    (inFlit[0]),
    .nFlit    (inFlit[1]),
    .eFlit    (inFlit[2]),
    .wFlit    (inFlit[3]),
    .sFlit    (inFlit[4]),
    .lReq     (inReq[0]),
    .nReq     (inReq[1]),
    .eReq     (inReq[2]),
    .wReq     (inReq[3]),
    .sReq     (inReq[4]),
    .grant    (grant),
    .outFlit  (outFlit),
    .outPort  (outPort),
    .outValid (outValid)
  );

  always #20 clk = ~clk;

  function automatic routerPkg::portSelT onePort(input int idx);
    return routerPkg::portSelT'(6'b000010 << idx);
  endfunction

  // -1 for idle or a bad code.
  function automatic int portIndex(input routerPkg::portSelT sel);
    int idx;
    idx = -1;
    for (int i = 0; i < routerPkg::NumPorts; i++)
    begin
      if (sel == onePort(i))
      begin
        idx = i;
      end
    end
    return idx;
  endfunction

  function automatic routerPkg::flitT headerFlit(input routerPkg::pktLenT len);
    return {routerPkg::FlitIdHeader, 1'b0, len};
  endfunction

  function automatic routerPkg::flitT bodyFlit(input logic [12:0] payload);
    return {3'b010, payload};
  endfunction

  function automatic void resetModel();
    for (int i = 0; i < routerPkg::NumPorts; i++)
    begin
      mFlit[i] = '0;
      mLimit[i] = '0;
      mCount[i] = '0;
      mDly[i] = '0;
    end
    mReq = '0;
    mState = routerPkg::ArbIdle;
    mOutFlit = '0;
    mOutPort = '0;
    mOutValid = 1'b0;
  endfunction

  // one clock of the router, from the inputs sampled at this edge.
  function automatic void stepModel();
    routerPkg::portSelT nextState;
    logic [routerPkg::NumPorts-1:0] run;
    int cur;
    int cand;
    nextState = routerPkg::ArbIdle;
    run = '0;
    cur = portIndex(mState);
    if (cur < 0)
    begin
      // fixed priority, local highest.
      for (int i = routerPkg::NumPorts - 1; i >= 0; i--)
      begin
        if (mReq[i])
        begin
          nextState = onePort(i);
        end
      end
    end
    else if (mReq[cur] && mCount[cur] != mLimit[cur])
    begin
      run[cur] = 1'b1;
      nextState = mState;
    end
    else
    begin
      for (int off = routerPkg::NumPorts - 1; off >= 1; off--)
      begin
        cand = (cur + off) % routerPkg::NumPorts;
        if (mReq[cand])
        begin
          nextState = onePort(cand);
        end
      end
    end
    mOutValid = (cur >= 0);
    mOutPort = mState;
    mOutFlit = (cur >= 0) ? mDly[cur] : '0;
    for (int i = 0; i < routerPkg::NumPorts; i++)
    begin
      mDly[i] = mFlit[i];
      if (mFlit[i][15:13] == routerPkg::FlitIdHeader)
      begin
        mLimit[i] = mFlit[i][11:0];
      end
      mCount[i] = run[i] ? mCount[i] + 12'd1 : 12'd0;
      mFlit[i] = inFlit[i];
    end
    mReq = inReq;
    mState = nextState;
  endfunction

  always @(posedge clk)
  begin
    if (rst)
    begin
      resetModel();
    end
    else
    begin
      stepModel();
    end
    for (int i = 0; i < routerPkg::NumPorts; i++)
    begin
      past2[i] = past1[i];
      past1[i] = past0[i];
      past0[i] = inFlit[i];
    end
  end

  task automatic reportMismatch(input string what, input logic [15:0] expected,
                                input logic [15:0] observed);
    $display("Error at %0t ns: %s expected %h observed %h", $time, what, expected, observed);
    errCount++;
  endtask

  always @(negedge clk)
  begin
    if (checking)
    begin
      if (grant !== mState)
      begin
        reportMismatch("grant", mState, grant);
      end
      if (outValid !== mOutValid)
      begin
        reportMismatch("outValid", mOutValid, outValid);
      end
      if (outPort !== mOutPort)
      begin
        reportMismatch("outPort", mOutPort, outPort);
      end
      if (outFlit !== mOutFlit)
      begin
        reportMismatch("outFlit", mOutFlit, outFlit);
      end
      // datapath against the pins, two edges back.
      if (outValid === 1'b1 && portIndex(outPort) < 0)
      begin
        reportMismatch("outPort one-hot code", 16'h0, outPort);
      end
      else if (outValid === 1'b1 && outFlit !== past2[portIndex(outPort)])
      begin
        reportMismatch("forwarded flit", past2[portIndex(outPort)], outFlit);
      end
    end
  end

  initial
  begin
    cycles = 0;
    @(posedge clk);
    while (cycles < cycleLimit)
    begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: the tests did not finish within %0d cycles", cycleLimit);
    $display("Simulation failed");
    $finish;
  end

  task automatic finishTest(input string name, input int startErr);
    if (errCount == startErr)
    begin
      passCount++;
      $display("test %s passed", name);
    end
    else
    begin
      failCount++;
      $display("test %s failed with %0d errors", name, errCount - startErr);
    end
  endtask

  task automatic waitForGrant(input routerPkg::portSelT target);
    int guard;
    guard = 0;
    @(negedge clk);
    while (grant !== target && guard < 20)
    begin
      @(negedge clk);
      guard++;
    end
    if (grant !== target)
    begin
      $display("grant %b never arrived, grant is %b", target, grant);
      errCount++;
    end
  endtask

  task automatic countHeld(input routerPkg::portSelT target, output int held);
    held = 0;
    while (grant === target && held < 100)
    begin
      held++;
      @(negedge clk);
    end
  endtask

  task automatic waitForChange(input routerPkg::portSelT from, output int edges);
    edges = 0;
    do
    begin
      @(posedge clk);
      edges++;
      @(negedge clk);
    end
    while (grant === from && edges < 20);
  endtask

  task automatic dropAll();
    @(posedge clk);
    inReq <= '0;
    for (int p = 0; p < routerPkg::NumPorts; p++)
    begin
      inFlit[p] <= '0;
    end
    repeat (6) @(posedge clk);
  endtask

  // every port sends a header of length base + port, then bodies.
  task automatic sendHeaders(input int base, input logic [routerPkg::NumPorts-1:0] ports);
    @(posedge clk);
    for (int p = 0; p < routerPkg::NumPorts; p++)
    begin
      if (ports[p])
      begin
        inFlit[p] <= headerFlit(routerPkg::pktLenT'(base + p));
        inReq[p] <= 1'b1;
      end
    end
    @(posedge clk);
    for (int p = 0; p < routerPkg::NumPorts; p++)
    begin
      if (ports[p])
      begin
        inFlit[p] <= bodyFlit(13'($random(seed)));
      end
    end
  endtask

  initial
  begin
    int startErr;
    int held;
    int edges;
    logic [31:0] r;
    seed = 3;
    clk = 1'b0;
    rst = 1'b1;
    inReq = '0;
    // payload on every port, nothing requested.
    for (int p = 0; p < routerPkg::NumPorts; p++)
    begin
      inFlit[p] = bodyFlit(13'($random(seed)));
    end
    errCount = 0;
    passCount = 0;
    failCount = 0;
    checking = 1'b0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    checking = 1'b1;

    startErr = errCount;
    repeat (4)
    begin
      @(negedge clk);
      if (grant !== routerPkg::ArbIdle || outValid !== 1'b0 || outFlit !== '0)
      begin
        $display("Error at %0t ns: outputs not idle after reset", $time);
        errCount++;
      end
    end
    finishTest("reset", startErr);

    // east alone, length 4.
    startErr = errCount;
    sendHeaders(2, 5'b00100);
    waitForGrant(routerPkg::ArbEast);
    countHeld(routerPkg::ArbEast, held);
    if (held != 5 || grant !== routerPkg::ArbIdle)
    begin
      $display("Error at %0t ns: east held %0d cycles expected 5, then grant %b",
               $time, held, grant);
      errCount++;
    end
    dropAll();
    finishTest("single port", startErr);

    startErr = errCount;
    sendHeaders(2, 5'b11111);
    waitForGrant(routerPkg::ArbLocal);
    for (int seg = 0; seg < routerPkg::NumPorts; seg++)
    begin
      if (grant !== onePort(seg))
      begin
        reportMismatch("rotation grant", onePort(seg), grant);
      end
      countHeld(onePort(seg), held);
      if (held != 3 + seg)
      begin
        reportMismatch("rotation hold cycles", 3 + seg, held);
      end
    end
    dropAll();
    finishTest("rotation", startErr);

    startErr = errCount;
    sendHeaders(20, 5'b11111);
    waitForGrant(routerPkg::ArbLocal);
    repeat (2) @(negedge clk);
    @(posedge clk);
    inReq[0] <= 1'b0;
    waitForChange(routerPkg::ArbLocal, edges);
    if (grant !== routerPkg::ArbNorth || edges != 2)
    begin
      $display("Error at %0t ns: after local dropped grant %b after %0d edges",
               $time, grant, edges);
      errCount++;
    end
    @(posedge clk);
    inReq <= '0;
    waitForChange(routerPkg::ArbNorth, edges);
    if (grant !== routerPkg::ArbIdle || edges != 2)
    begin
      $display("Error at %0t ns: after all dropped grant %b after %0d edges",
               $time, grant, edges);
      errCount++;
    end
    dropAll();
    finishTest("early drop", startErr);

    startErr = errCount;
    for (int c = 0; c < 400; c++)
    begin
      @(posedge clk);
      for (int p = 0; p < routerPkg::NumPorts; p++)
      begin
        r = $random(seed);
        if (r[2:0] == 3'd0)
        begin
          inReq[p] <= ~inReq[p];
        end
        if (r[5:4] == 2'd0)
        begin
          inFlit[p] <= headerFlit(routerPkg::pktLenT'(r[10:8]));
        end
        else
        begin
          inFlit[p] <= bodyFlit(r[28:16]);
        end
      end
    end
    dropAll();
    finishTest("random traffic", startErr);

    $display("tests passed: %0d, failed: %0d", passCount, failCount);
    if (failCount == 0 && errCount == 0)
    begin
      $display("Simulation completed successfully");
    end
    else
    begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* verif/routerArb_props.sv */
`timescale 1ns/1ps

module routerArb_props (
  input  logic                           clk,
  input  logic                           rst,
  input  routerPkg::portSelT             grant,
  input  logic [routerPkg::NumPorts-1:0] req,
  input  logic [routerPkg::NumPorts-1:0] timesUp,
  input  logic                           outValid
);

  // idle counts as one of the hot bits.
  grantOneHot: assert property (
    @(posedge clk) disable iff (rst)
    $onehot(grant))
    else $error("grant %b is not one-hot", grant);

  validFollowsGrant: assert property (
    @(posedge clk) disable iff (rst)
    outValid == ($past(grant) != routerPkg::ArbIdle))
    else $error("outValid %b does not follow the previous grant", outValid);

  // held request with time left keeps the port.
  grantHeld: assert property (
    @(posedge clk) disable iff (rst)
    ((grant[routerPkg::NumPorts:1] & req & ~timesUp) != '0) |=> (grant == $past(grant)))
    else $error("grant %b moved while its request was held", $past(grant));

endmodule
